/* Makefile */
# Verilator build and run of the divider testbench in both buffer modes

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench in skid mode and in half mode"
	@echo "make clean  remove the build folders and the log"
	@echo "make help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --timescale 1ns/100ps -f pulse_divider.f \
		--top-module pulse_divider_tb -Gmode=0 --Mdir obj_skid -o sim_skid
	verilator --binary --timing --timescale 1ns/100ps -f pulse_divider.f \
		--top-module pulse_divider_tb -Gmode=1 --Mdir obj_half -o sim_half
	./obj_skid/sim_skid | tee -a $(LOG)
	./obj_half/sim_half | tee -a $(LOG)
	@test "$$(grep -c '^Simulation passed$$' $(LOG))" -eq 2 || \
		{ echo "test run failed, see $(LOG)"; exit 1; }
	@echo "both buffer modes ran clean"

clean:
	rm -rf obj_skid obj_half $(LOG)

/* pulse_divider.f */
verilog/pulse_div_pkg.sv
verilog/div_iter_if.sv
verilog/div_datapath.sv
verilog/div_controller.sv
verilog/pipeline_output_buffer.sv
verilog/pulse_to_pipeline.sv
verilog/pulse_divider.sv
verif/pulse_divider_checker.sv
verif/pulse_divider_tb.sv

/* verif/pulse_divider_checker.sv */
// result checker for the iterative divider testbench
//   reference model with the divide by zero rule
//   queue of expected results, filled on each input transfer
//   in order compare, latency bound and half mode blocking check
//   one line per finished test and running counts for the summary

`timescale 1ns/100ps

module pulse_divider_checker #(
    parameter pulse_div_pkg::buffer_mode_e buffer_mode = pulse_div_pkg::buf_skid,
    parameter int                          word_width  = 16
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  logic [word_width-1:0] dividend,
    input  logic [word_width-1:0] divisor,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  logic [word_width-1:0] quotient,
    input  logic [word_width-1:0] remainder,
    input  int                    test_id,
    output int                    error_count,
    output int                    in_count,
    output int                    out_count,
    output int                    tests_reported
);

    logic [word_width-1:0] exp_quo_q[$];
    logic [word_width-1:0] exp_rem_q[$];
    // rising edge number on which each pending operand pair was accepted
    int accept_q[$];
    int edge_count   = 0;
    int current_test = 0;
    int test_errors  = 0;
    int test_outputs = 0;
    int errors       = 0;
    int inputs       = 0;
    int outputs      = 0;
    int reported     = 0;

    assign error_count    = errors;
    assign in_count       = inputs;
    assign out_count      = outputs;
    assign tests_reported = reported;

    function automatic string test_name(input int id);
        string name;
        case (id)
            0: name = "reset_state";
            1: name = "random_division";
            2: name = "edge_values";
            3: name = "back_pressure";
            4: name = "continuous_input";
            5: name = "latency";
            default: name = "unknown";
        endcase
        return name;
    endfunction

    task automatic flag_error();
        errors++;
        test_errors++;
    endtask

    task automatic record_input();
        logic [word_width-1:0] quo;
        logic [word_width-1:0] rem;
        // a zero divisor yields all ones and leaves the dividend as remainder
        if (divisor == '0) begin
            quo = '1;
            rem = dividend;
        end else begin
            quo = dividend / divisor;
            rem = dividend % divisor;
        end
        exp_quo_q.push_back(quo);
        exp_rem_q.push_back(rem);
        accept_q.push_back(edge_count);
        inputs++;
        // half mode keeps the divider parked while a result sits unread
        if (buffer_mode == pulse_div_pkg::buf_half && out_valid && !out_ready) begin
            $display("%s: operands accepted while a result was stalled in half mode",
                     test_name(current_test));
            flag_error();
        end
    endtask

    task automatic check_output();
        logic [word_width-1:0] exp_quo;
        logic [word_width-1:0] exp_rem;
        int                    latency;
        outputs++;
        test_outputs++;
        if (exp_quo_q.size() == 0) begin
            $display("%s: result transfer with no operand pair pending",
                     test_name(current_test));
            flag_error();
        end else begin
            exp_quo = exp_quo_q.pop_front();
            exp_rem = exp_rem_q.pop_front();
            latency = edge_count - accept_q.pop_front();
            if (quotient !== exp_quo) begin
                $display("[ERROR] %s: quotient expected 0x%h actual 0x%h",
                         test_name(current_test), exp_quo, quotient);
                flag_error();
            end
            if (remainder !== exp_rem) begin
                $display("[ERROR] %s: remainder expected 0x%h actual 0x%h",
                         test_name(current_test), exp_rem, remainder);
                flag_error();
            end
            // the result pulse alone needs word_width + 1 cycles after acceptance
            if (latency < word_width + 1) begin
                $display("[ERROR] %s: latency expected at least %0d actual %0d",
                         test_name(current_test), word_width + 1, latency);
                flag_error();
            end
        end
    endtask

    task automatic report_test();
        string verdict;
        if (test_errors == 0) begin
            verdict = "ok";
        end else begin
            verdict = "FAILED";
        end
        $display("test %0d %s: %0d results, %0d errors, %s", current_test,
                 test_name(current_test), test_outputs, test_errors, verdict);
        reported++;
        test_errors  = 0;
        test_outputs = 0;
        current_test = test_id;
    endtask

    // all inputs are driven on the falling edge, so they are settled here
    always @(posedge clock) begin
        edge_count++;
        if (test_id != current_test) begin
            report_test();
        end
        if (!rst_n) begin
            if (out_valid) begin
                $display("%s: out_valid high during reset", test_name(current_test));
                flag_error();
            end
        end else begin
            // outputs first, a pair accepted on this edge cannot be finished yet
            if (out_valid && out_ready) begin
                check_output();
            end
            if (in_valid && in_ready) begin
                record_input();
            end
        end
    end

endmodule

/* verif/pulse_divider_tb.sv */
// testbench for the iterative divider
//   clock, reset and a Galois LFSR behind every random choice
//   operand driver with random gaps, out_ready pattern, all on the falling edge
//   DUT, result checker and the closing summary

`timescale 1ns/100ps

module pulse_divider_tb #(
    parameter int mode = 0
);

    localparam pulse_div_pkg::buffer_mode_e buf_mode = pulse_div_pkg::buffer_mode_e'(mode);
    localparam int width      = pulse_div_pkg::result_word_width;
    localparam int wait_limit = 4000;

    logic             clock;
    logic             rst_n;
    logic             in_valid;
    logic             in_ready;
    logic [width-1:0] dividend;
    logic [width-1:0] divisor;
    logic             out_valid;
    logic             out_ready;
    logic [width-1:0] quotient;
    logic [width-1:0] remainder;
    int               test_id;
    int               error_count;
    int               in_count;
    int               out_count;
    int               tests_reported;
    logic [31:0]      lfsr;
    // when set, out_ready gets a fresh random bit every cycle
    logic             ready_random;

    // right shifting Galois form of a maximal length 32 bit polynomial
    function automatic logic [31:0] lfsr_step(input logic [31:0] value);
        logic [31:0] shifted;
        shifted = value >> 1;
        if (value[0]) begin
            shifted = shifted ^ 32'h8020_0003;
        end
        return shifted;
    endfunction

    function automatic logic next_bit();
        logic taken;
        taken = lfsr[0];
        lfsr = lfsr_step(lfsr);
        return taken;
    endfunction

    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], next_bit()};
        end
        return value;
    endfunction

    function automatic logic [width-1:0] random_word();
        return width'(next_bits(width));
    endfunction

    // shifting right by a random amount favours small divisors and zero
    function automatic logic [width-1:0] random_divisor();
        int               shift;
        logic [width-1:0] value;
        shift = int'(next_bits(4));
        value = width'(next_bits(width));
        return value >> shift;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic tick();
        @(negedge clock);
        if (ready_random) begin
            out_ready = next_bit();
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_pair(input logic [width-1:0] a, input logic [width-1:0] b,
                             input logic gaps);
        int waited;
        int idle;
        in_valid = 1'b1;
        dividend = a;
        divisor  = b;
        waited   = 0;
        while (!in_ready) begin
            tick();
            waited++;
            if (waited > wait_limit) begin
                abort_run("timeout: the DUT never took the next operand pair");
            end
        end
        tick();
        if (gaps) begin
            idle = int'(next_bits(2));
            if (idle != 0) begin
                in_valid = 1'b0;
                for (int k = 0; k < idle; k++) begin
                    tick();
                end
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (out_count != in_count) begin
            tick();
            waited++;
            if (waited > wait_limit) begin
                abort_run("timeout: accepted operand pairs never produced their results");
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    pulse_divider #(
        .buffer_mode (buf_mode)
    ) u_pulse_divider (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .dividend  (dividend),
        .divisor   (divisor),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .quotient  (quotient),
        .remainder (remainder)
    );

    pulse_divider_checker #(
        .buffer_mode (buf_mode),
        .word_width  (width)
    ) result_check (
        .clock          (clock),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .dividend       (dividend),
        .divisor        (divisor),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .quotient       (quotient),
        .remainder      (remainder),
        .test_id        (test_id),
        .error_count    (error_count),
        .in_count       (in_count),
        .out_count      (out_count),
        .tests_reported (tests_reported)
    );

    initial begin
        int waited;
        lfsr         = 32'hb24a_238a;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        dividend     = '0;
        divisor      = '0;
        out_ready    = 1'b1;
        ready_random = 1'b0;
        test_id      = 0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_n  = 1'b1;
        waited = 0;
        while (!in_ready) begin
            tick();
            waited++;
            if (waited > 4) begin
                abort_run("in_ready did not rise after reset was released");
            end
        end

        test_id = 1;
        for (int n = 0; n < 200; n++) begin
            send_pair(random_word(), random_divisor(), 1'b1);
        end
        in_valid = 1'b0;
        wait_drain();

        test_id = 2;
        send_pair(16'h1234, 16'h0000, 1'b0);
        send_pair(16'hffff, 16'h0000, 1'b0);
        send_pair(16'h0000, 16'h0000, 1'b0);
        send_pair(16'habcd, 16'h0001, 1'b0);
        send_pair(16'hffff, 16'h0001, 1'b0);
        send_pair(16'h0000, 16'h5a5a, 1'b0);
        send_pair(16'hffff, 16'hffff, 1'b0);
        send_pair(16'hffff, 16'h8000, 1'b0);
        send_pair(16'h0001, 16'hffff, 1'b0);
        send_pair(16'h7fff, 16'hfffe, 1'b0);
        for (int n = 0; n < 20; n++) begin
            send_pair(random_word(), width'(n % 2), 1'b1);
        end
        in_valid = 1'b0;
        wait_drain();

        // out_ready is low about half of the cycles from here on
        test_id      = 3;
        ready_random = 1'b1;
        for (int n = 0; n < 200; n++) begin
            send_pair(random_word(), random_divisor(), 1'b1);
        end
        in_valid = 1'b0;
        wait_drain();

        test_id = 4;
        for (int n = 0; n < 100; n++) begin
            send_pair(random_word(), random_divisor(), 1'b0);
        end
        in_valid = 1'b0;
        wait_drain();

        // one pair at a time into an empty buffer
        test_id      = 5;
        ready_random = 1'b0;
        out_ready    = 1'b1;
        for (int n = 0; n < 20; n++) begin
            send_pair(random_word(), random_divisor(), 1'b0);
            in_valid = 1'b0;
            wait_drain();
        end

        test_id = 6;
        waited  = 0;
        while (tests_reported < 6) begin
            tick();
            waited++;
            if (waited > 10) begin
                abort_run("the checker did not report the last test");
            end
        end
        $display("summary: %0d inputs, %0d outputs, %0d errors",
                 in_count, out_count, error_count);
        if (error_count == 0 && in_count == out_count) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog/div_controller.sv */
// divider sequencing FSM
//   input handshake, accepted only in st_idle
//   iteration counter sized from word_width
//   one cycle result pulse on entry to st_done
//   hold in st_done until the output side reports the handoff

`timescale 1ns/100ps

module div_controller #(
    parameter int word_width = 16
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    output logic       result_pulse,
    input  logic       module_ready,
    div_iter_if.ctrl   iter
);

    // the counter only has to reach word_width - 1
    localparam int count_width = (word_width > 1) ? $clog2(word_width) : 1;
    localparam logic [count_width-1:0] last_count = count_width'(word_width - 1);

    pulse_div_pkg::div_state_e state;
    pulse_div_pkg::div_state_e state_next;
    logic [count_width-1:0]    count;
    logic                      last_step;

    // operands are taken only while nothing is in flight
    assign in_ready = (state == pulse_div_pkg::st_idle);

    // the load strobe is the input transfer itself
    assign iter.load = in_ready && in_valid;

    // a zero divisor was already resolved at load time, so the datapath
    // is left alone for those iterations and simply holds its result
    assign iter.step = (state == pulse_div_pkg::st_run) && iter.rem_ready
                       && !iter.divisor_zero;

    // final iteration, the counter still runs for a zero divisor so the
    // latency does not depend on the operands
    assign last_step = (state == pulse_div_pkg::st_run) && (count == last_count);

    always_comb begin
        state_next = state;
        unique case (state)
            pulse_div_pkg::st_idle: begin
                if (in_valid) begin
                    state_next = pulse_div_pkg::st_run;
                end
            end
            pulse_div_pkg::st_run: begin
                if (count == last_count) begin
                    state_next = pulse_div_pkg::st_done;
                end
            end
            pulse_div_pkg::st_done: begin
                // the result must be owned by the output side before the
                // datapath registers may be overwritten
                if (module_ready) begin
                    state_next = pulse_div_pkg::st_idle;
                end
            end
            default: begin
                state_next = pulse_div_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state        <= pulse_div_pkg::st_idle;
            count        <= '0;
            result_pulse <= 1'b0;
        end else begin
            state <= state_next;
            // restart the count with every new operand pair
            if (iter.load) begin
                count <= '0;
            end else if (state == pulse_div_pkg::st_run) begin
                count <= count + 1'b1;
            end
            // registered, so the pulse lines up with the first st_done cycle
            result_pulse <= last_step;
        end
    end

endmodule

/* verilog/div_datapath.sv */
// restoring shift and subtract datapath, one quotient bit per step
//   divisor, partial remainder and quotient registers
//   trial subtraction of the divisor from the shifted remainder
//   divisor_zero and rem_ready status for the controller

`timescale 1ns/100ps

module div_datapath #(
    parameter int word_width = 16
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic [word_width-1:0]       dividend,
    input  logic [word_width-1:0]       divisor,
    div_iter_if.dp                      iter,
    output pulse_div_pkg::div_result_t  result
);

    logic [word_width-1:0] divisor_q;
    logic [word_width-1:0] rem_q;
    // holds the unconsumed dividend bits at the top and the quotient
    // bits collected so far at the bottom
    logic [word_width-1:0] quo_q;
    logic [word_width:0]   trial;
    logic [word_width:0]   diff;
    logic                  fits;
    logic [word_width-1:0] rem_next;
    logic                  rem_ready_q;

    // bring down the next dividend bit next to the partial remainder
    assign trial = {rem_q, quo_q[word_width-1]};
    assign diff  = trial - {1'b0, divisor_q};
    assign fits  = (trial >= {1'b0, divisor_q});

    // after a successful subtraction the remainder is below the divisor,
    // and after a failed one the trial value is, so word_width bits suffice
    assign rem_next = fits ? diff[word_width-1:0] : trial[word_width-1:0];

    always_ff @(posedge clock) begin
        if (iter.load) begin
            divisor_q <= divisor;
            if (divisor == '0) begin
                // this is what word_width restoring steps would produce
                // against a zero divisor, every trial subtraction fits
                quo_q <= '1;
                rem_q <= dividend;
            end else begin
                quo_q <= dividend;
                rem_q <= '0;
            end
        end else if (iter.step) begin
            rem_q <= rem_next;
            quo_q <= {quo_q[word_width-2:0], fits};
        end
    end

    // set once the first operand pair has been captured
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rem_ready_q <= 1'b0;
        end else if (iter.load) begin
            rem_ready_q <= 1'b1;
        end
    end

    assign iter.rem_ready    = rem_ready_q;
    assign iter.divisor_zero = (divisor_q == '0);

    // registers stay put between the result pulse and the next load
    assign result.quotient  = quo_q;
    assign result.remainder = rem_q;

endmodule

/* verilog/div_iter_if.sv */
// control and status link between the divider FSM and its datapath
//   load, step          : strobes from the controller
//   divisor_zero        : captured divisor is zero
//   rem_ready           : partial remainder holds a loaded operand pair

`timescale 1ns/100ps

interface div_iter_if;

    // one cycle strobe that captures a new operand pair
    logic load;
    // high for every iteration that should shift and subtract
    logic step;
    // status back from the datapath
    logic divisor_zero;
    logic rem_ready;

    modport ctrl (
        output load,
        output step,
        input  divisor_zero,
        input  rem_ready
    );

    modport dp (
        input  load,
        input  step,
        output divisor_zero,
        output rem_ready
    );

endinterface

/* verilog/pipeline_output_buffer.sv */
// ready/valid output buffer for one quotient and remainder pair
//   skid mode with a main and a skid register
//   half mode with a single register
//   in_ready comes from registers only, never from out_ready

`timescale 1ns/100ps

module pipeline_output_buffer #(
    parameter int                          word_width  = 16,
    parameter pulse_div_pkg::buffer_mode_e buffer_mode = pulse_div_pkg::buf_skid
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [2*word_width-1:0]     in_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [2*word_width-1:0]     out_data
);

    // a quotient and a remainder of word_width bits each
    localparam int data_width = 2 * word_width;

    logic                  main_valid;
    logic [data_width-1:0] main_data;
    logic                  in_fire;
    logic                  out_fire;

    assign in_fire   = in_valid && in_ready;
    assign out_fire  = main_valid && out_ready;
    assign out_valid = main_valid;
    assign out_data  = main_data;

    generate
        if (buffer_mode == pulse_div_pkg::buf_skid) begin : g_skid
            logic                  skid_valid;
            logic [data_width-1:0] skid_data;
            logic                  load_main;

            // the skid register only fills while main is full and stalled,
            // so in_ready drops only with both registers occupied
            assign in_ready  = !skid_valid;
            assign load_main = !main_valid || out_ready;

            always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                    main_valid <= 1'b0;
                    skid_valid <= 1'b0;
                end else if (skid_valid) begin
                    // main refills from skid on a read, so it stays valid
                    if (out_fire) begin
                        skid_valid <= 1'b0;
                    end
                end else if (in_fire) begin
                    main_valid <= 1'b1;
                    skid_valid <= !load_main;
                end else if (out_fire) begin
                    main_valid <= 1'b0;
                end
            end

            always_ff @(posedge clock) begin
                if (skid_valid) begin
                    if (out_fire) begin
                        main_data <= skid_data;
                    end
                end else if (in_fire) begin
                    if (load_main) begin
                        main_data <= in_data;
                    end else begin
                        skid_data <= in_data;
                    end
                end
            end
        end else begin : g_half
            // a full register blocks the input even during a read, which
            // halves the peak rate but keeps in_ready registered
            assign in_ready = !main_valid;

            always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                    main_valid <= 1'b0;
                end else if (in_fire) begin
                    main_valid <= 1'b1;
                end else if (out_fire) begin
                    main_valid <= 1'b0;
                end
            end

            always_ff @(posedge clock) begin
                if (in_fire) begin
                    main_data <= in_data;
                end
            end
        end
    endgenerate

endmodule

/* verilog/pulse_div_pkg.sv */
// shared definitions for the iterative divider
//   result_word_width : operand and result width used by the result struct
//   buffer_mode_e     : output buffer behaviour, skid or half
//   div_state_e       : controller FSM states
//   div_result_t      : quotient and remainder pair handed to the output side

package pulse_div_pkg;

    // the result struct is sized from this constant, so the top level
    // derives its operand width from here as well
    localparam int result_word_width = 16;

    // int based so a testbench can select the mode with a plain integer
    typedef enum int {
        buf_skid,
        buf_half
    } buffer_mode_e;

    // idle waits for operands, run does one quotient bit per clock,
    // done holds the result until the output side has taken it
    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } div_state_e;

    // quotient sits in the upper half of the packed vector
    typedef struct packed {
        logic [result_word_width-1:0] quotient;
        logic [result_word_width-1:0] remainder;
    } div_result_t;

endpackage

/* verilog/pulse_divider.sv */
// top level of the iterative unsigned divider
//   operand input with a ready/valid handshake
//   controller, datapath and their status interface
//   pulse to pipeline stage that drives the result handshake

`timescale 1ns/100ps

module pulse_divider #(
    parameter pulse_div_pkg::buffer_mode_e buffer_mode = pulse_div_pkg::buf_skid
) (
    input  logic                                        clock,
    input  logic                                        rst_n,
    input  logic                                        in_valid,
    output logic                                        in_ready,
    input  logic [pulse_div_pkg::result_word_width-1:0] dividend,
    input  logic [pulse_div_pkg::result_word_width-1:0] divisor,
    output logic                                        out_valid,
    input  logic                                        out_ready,
    output logic [pulse_div_pkg::result_word_width-1:0] quotient,
    output logic [pulse_div_pkg::result_word_width-1:0] remainder
);

    // operand width follows the result struct
    localparam int word_width = pulse_div_pkg::result_word_width;

    logic                       result_pulse;
    logic                       module_ready;
    pulse_div_pkg::div_result_t dp_result;
    pulse_div_pkg::div_result_t out_data;

    div_iter_if iter_bus ();

    div_controller #(
        .word_width (word_width)
    ) u_controller (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .result_pulse (result_pulse),
        .module_ready (module_ready),
        .iter         (iter_bus)
    );

    div_datapath #(
        .word_width (word_width)
    ) u_datapath (
        .clock    (clock),
        .rst_n    (rst_n),
        .dividend (dividend),
        .divisor  (divisor),
        .iter     (iter_bus),
        .result   (dp_result)
    );

    pulse_to_pipeline #(
        .word_width  (word_width),
        .buffer_mode (buffer_mode)
    ) u_pulse_to_pipeline (
        .clock             (clock),
        .rst_n             (rst_n),
        .module_data       (dp_result),
        .module_data_valid (result_pulse),
        .module_ready      (module_ready),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .out_data          (out_data)
    );

    assign quotient  = out_data.quotient;
    assign remainder = out_data.remainder;

endmodule

/* verilog/pulse_to_pipeline.sv */
// turns the one cycle result pulse into a ready/valid output
//   set/clear latch that keeps the pulse until the buffer takes it
//   output buffer in skid or half mode
//   module_ready back to the controller

`timescale 1ns/100ps

module pulse_to_pipeline #(
    parameter int                         word_width  = 16,
    parameter pulse_div_pkg::buffer_mode_e buffer_mode = pulse_div_pkg::buf_skid
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  pulse_div_pkg::div_result_t  module_data,
    input  logic                        module_data_valid,
    output logic                        module_ready,
    output logic                        out_valid,
    input  logic                        out_ready,
    output pulse_div_pkg::div_result_t  out_data
);

    logic valid_latched;
    logic internal_valid;
    logic internal_ready;
    logic accept;
    logic buf_out_valid;

    // the live pulse is ORed in so a buffer with room takes the result in
    // the pulse cycle itself, the latch covers the cycles where it cannot
    assign internal_valid = valid_latched || module_data_valid;
    assign accept         = internal_valid && internal_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_latched <= 1'b0;
        end else if (accept) begin
            valid_latched <= 1'b0;
        end else if (module_data_valid) begin
            valid_latched <= 1'b1;
        end
    end

    generate
        if (buffer_mode == pulse_div_pkg::buf_skid) begin : g_skid_ready
            // the divider may start over as soon as the buffer owns the result
            assign module_ready = accept;
        end else begin : g_half_ready
            logic held;

            // half mode keeps the divider parked until the buffered result
            // has been read out, held marks a result that is still inside
            always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                    held <= 1'b0;
                end else if (module_ready) begin
                    held <= 1'b0;
                end else if (accept) begin
                    held <= 1'b1;
                end
            end

            // only registered terms, so out_ready never reaches the controller
            assign module_ready = held && !buf_out_valid;
        end
    endgenerate

    pipeline_output_buffer #(
        .word_width  (word_width),
        .buffer_mode (buffer_mode)
    ) output_buffer (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (internal_valid),
        .in_ready  (internal_ready),
        .in_data   (module_data),
        .out_valid (buf_out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    assign out_valid = buf_out_valid;

endmodule
